// File: filelist.f
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/decode_unit.sv
rtl/data_mem.sv
rtl/cpu.sv
verif/cpu_sva.sv
verif/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/reg_file.sv
      - rtl/alu.sv
      - rtl/decode_unit.sv
      - rtl/data_mem.sv
      - rtl/cpu.sv
  - target: test
    files:
      - verif/cpu_sva.sv
      - verif/cpu_tb.sv

// File: verif/cpu_tb.sv
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  localparam int N_RANDOM   = 200;
  localparam int MAX_CYCLES = 4000;

  logic        clk = 1'b0;
  logic        arst_n;
  logic [15:0] instr;
  logic [15:0] pc;
  logic        hlt;
  wb_t         wb;

  logic [15:0] prog [1024];
  logic [15:0] model_rf [16];
  logic [15:0] model_mem [32768];
  wb_t         exp_q [$];         // Writebacks in program order
  logic [31:0] lfsr_state = 32'd83725;
  int          plen;
  int          hlt_idx;
  int          depth;

  cpu u_dut (
    .clk    (clk),
    .arst_n (arst_n),
    .instr  (instr),
    .pc     (pc),
    .hlt    (hlt),
    .wb     (wb)
  );

  always #4 clk = ~clk;

  assign instr = prog[pc[10:1]];  // Combinational instruction ROM

  ////////////////////
  // Random source
  ////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[14:0], lfsr_state[0]};  // One step per bit
    end
    return v;
  endfunction

  // Instruction plus the three NOPs of the hazard gap
  task automatic emit(input logic [15:0] w);
    prog[plen] = w;
    plen += 4;
  endtask

  task automatic gen_program();
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [3:0]  src;
    logic [15:0] sel;
    logic [15:0] off;
    logic [15:0] lo8;
    logic [15:0] base;
    for (int i = 0; i < 1024; i++) begin
      prog[i] = NOP_WORD;
    end
    plen = 0;
    // r14 and r15 hold memory bases and are never overwritten
    for (int b = 14; b < 16; b++) begin
      base = 16'((16 + rand_bits(16) % (depth - 32)) * 2);
      emit({OP_LLB, 4'(b), base[7:0]});
      emit({OP_LHB, 4'(b), base[15:8]});
    end
    for (int k = 0; k < N_RANDOM; k++) begin
      op  = 4'(rand_bits(4));
      rd  = 4'(rand_bits(4) % 14);
      src = 4'(rand_bits(4));
      sel = rand_bits(1);
      off = rand_bits(4);
      lo8 = rand_bits(8);
      if (op == OP_HLT) begin
        op = OP_NOP;  // Only one HLT at the end
      end
      if (op == OP_LW || op == OP_SW) begin
        emit({op, (op == OP_SW) ? src : rd, 3'b111, sel[0], off[3:0]});
      end else begin
        emit({op, rd, lo8[7:0]});
      end
    end
    hlt_idx       = plen;
    prog[hlt_idx] = {OP_HLT, 12'h000};
    plen          = plen + 1;
  endtask

  ////////////////////
  // ISA model
  ////////////////////
  task automatic run_model();
    logic [15:0] w;
    logic [15:0] res;
    logic [15:0] addr;
    logic [15:0] soff;
    logic        wr;
    for (int r = 0; r < 16; r++) begin
      model_rf[r] = '0;
    end
    for (int a = 0; a < 32768; a++) begin
      model_mem[a] = '0;
    end
    for (int i = 0; i < plen; i++) begin
      w    = prog[i];
      wr   = 1'b1;
      res  = '0;
      soff = {{12{w[3]}}, w[3:0]};
      addr = model_rf[w[7:4]] + (soff << 1);  // Byte address
      case (w[15:12])
        OP_ADD: res = model_rf[w[7:4]] + model_rf[w[3:0]];
        OP_SUB: res = model_rf[w[7:4]] - model_rf[w[3:0]];
        OP_XOR: res = model_rf[w[7:4]] ^ model_rf[w[3:0]];
        OP_AND: res = model_rf[w[7:4]] & model_rf[w[3:0]];
        OP_OR:  res = model_rf[w[7:4]] | model_rf[w[3:0]];
        OP_SLL: res = model_rf[w[7:4]] << model_rf[w[3:0]][3:0];
        OP_SRL: res = model_rf[w[7:4]] >> model_rf[w[3:0]][3:0];
        OP_LW:  res = model_mem[(addr >> 1) % depth];
        OP_LLB: res = {model_rf[w[11:8]][15:8], w[7:0]};
        OP_LHB: res = {w[7:0], model_rf[w[11:8]][7:0]};
        OP_SW: begin
          wr = 1'b0;
          model_mem[(addr >> 1) % depth] = model_rf[w[11:8]];
        end
        default: wr = 1'b0;  // NOP, HLT, C to E
      endcase
      if (wr) begin
        model_rf[w[11:8]] = res;
        exp_q.push_back(wb_t'{valid: 1'b1, dst: w[11:8], data: res});
      end
    end
  endtask

  ////////////////////
  // Checks
  ////////////////////
  task automatic fail_stop();
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_wb(input wb_t got, input wb_t want);
    if (got !== want) begin
      $display("Fail at %0t: wb v=%0b r%0d=%h, expected v=%0b r%0d=%h", $time,
               got.valid, got.dst, got.data, want.valid, want.dst, want.data);
      fail_stop();
    end
  endtask

  task automatic check_pc(input logic [15:0] got, input logic [15:0] want);
    if (got !== want) begin
      $display("Fail at %0t: pc %h, expected %h", $time, got, want);
      fail_stop();
    end
  endtask

  task automatic check_hlt(input logic got, input logic want);
    if (got !== want) begin
      $display("Fail at %0t: hlt %0b, expected %0b", $time, got, want);
      fail_stop();
    end
  endtask

  initial begin
    int  n;
    int  tail;
    wb_t want;
    arst_n = 1'b0;
    depth  = 1 << u_dut.DMEM_AW;
    gen_program();
    run_model();
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    n    = 0;
    tail = 0;
    while (tail < 8) begin  // A few quiet cycles after hlt
      @(negedge clk);
      if (n == MAX_CYCLES) begin
        $display("Timeout: hlt did not rise within %0d cycles", MAX_CYCLES);
        fail_stop();
      end
      check_pc(pc, 16'(2 * ((n < hlt_idx + 1) ? n : hlt_idx + 1)));
      check_hlt(hlt, n >= hlt_idx + 4);
      if (wb.valid) begin
        if (hlt) begin
          $display("A writeback appeared after hlt was raised");
          fail_stop();
        end else if (exp_q.size() == 0) begin
          $display("A writeback appeared that no instruction should produce");
          fail_stop();
        end else begin
          want = exp_q.pop_front();
          check_wb(wb, want);
        end
      end
      if (hlt) begin
        tail++;
      end
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected writebacks never appeared", exp_q.size());
      fail_stop();
    end else begin
      $display("All tests passed!");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/cpu_sva.sv
`default_nettype none

module cpu_sva (
  input logic         clk,
  input logic         arst_n,
  input logic [15:0]  pc,
  input logic         hlt,
  input logic         halted,
  input cpu_pkg::wb_t wb
);

  ////////////////////
  // Halt behavior
  ////////////////////
  hlt_sticky: assert property (@(posedge clk) disable iff (!arst_n) hlt |=> hlt)
    else $error("hlt fell without a reset");

  wb_quiet_after_hlt: assert property (@(posedge clk) disable iff (!arst_n)
    hlt |-> !wb.valid)
    else $error("writeback valid after hlt");

  // PC steps until HLT is decoded
  pc_step: assert property (@(posedge clk) disable iff (!arst_n)
    (arst_n && !halted) |=> (halted || pc == $past(pc) + 16'd2))
    else $error("pc did not advance by 2");

endmodule

bind cpu cpu_sva u_sva (
  .clk    (clk),
  .arst_n (arst_n),
  .pc     (pc),
  .hlt    (hlt),
  .halted (halted),
  .wb     (wb)
);

`default_nettype wire

// File: rtl/cpu.sv
`default_nettype none

module cpu #(
  parameter int DMEM_AW = 8
) (
  input  logic         clk,
  input  logic         arst_n,
  input  logic [15:0]  instr,
  output logic [15:0]  pc,
  output logic         hlt,
  output cpu_pkg::wb_t wb
);
  import cpu_pkg::*;

  logic        halted;      // HLT has been decoded
  instr_u      if_id_q;
  logic [3:0]  rf_ra;
  logic [3:0]  rf_rb;
  logic [15:0] rf_da;
  logic [15:0] rf_db;
  id_ex_t      id_ex_d;
  id_ex_t      id_ex_q;
  logic [15:0] alu_b;
  logic [15:0] alu_y;
  ex_mem_t     ex_mem_q;
  logic [15:0] mem_rdata;
  ctrl_t       mem_wb_ctrl;
  logic [15:0] mem_wb_result;
  logic [3:0]  mem_wb_dst;

  ////////////////////
  // Fetch
  ////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc      <= 16'h0000;
      halted  <= 1'b0;
      if_id_q <= NOP_WORD;
    end else begin
      if (!(halted || id_ex_d.ctrl.halt)) begin
        pc <= pc + 16'd2;
      end
      halted  <= halted | id_ex_d.ctrl.halt;
      if_id_q <= instr;
    end
  end

  ////////////////////
  // Decode
  ////////////////////
  decode_unit u_decode (
    .instr  (if_id_q),
    .halted (halted),
    .ra     (rf_ra),
    .rb     (rf_rb),
    .da     (rf_da),
    .db     (rf_db),
    .id_ex  (id_ex_d)
  );

  // Written from the writeback stage
  reg_file u_rf (
    .clk    (clk),
    .arst_n (arst_n),
    .ra     (rf_ra),
    .rb     (rf_rb),
    .we     (wb.valid),
    .wa     (wb.dst),
    .wd     (wb.data),
    .da     (rf_da),
    .db     (rf_db)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex_q <= '{ctrl: NOP_CTRL, default: '0};
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  ////////////////////
  // Execute
  ////////////////////
  assign alu_b = id_ex_q.ctrl.use_imm ? id_ex_q.imm : id_ex_q.opb;

  alu u_alu (
    .op (id_ex_q.ctrl.alu_op),
    .a  (id_ex_q.opa),
    .b  (alu_b),
    .y  (alu_y)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem_q <= '{ctrl: NOP_CTRL, default: '0};
    end else begin
      ex_mem_q <= '{ctrl: id_ex_q.ctrl, result: alu_y,
                    store_data: id_ex_q.opb, dst: id_ex_q.dst};
    end
  end

  ////////////////////
  // Memory
  ////////////////////
  data_mem #(.DMEM_AW(DMEM_AW)) u_dmem (
    .clk    (clk),
    .arst_n (arst_n),
    .addr   (ex_mem_q.result),
    .wdata  (ex_mem_q.store_data),
    .we     (ex_mem_q.ctrl.mem_write),
    .re     (ex_mem_q.ctrl.mem_read),
    .rdata  (mem_rdata)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_wb_ctrl   <= NOP_CTRL;
      mem_wb_result <= 16'h0000;
      mem_wb_dst    <= 4'h0;
      hlt           <= 1'b0;
    end else begin
      mem_wb_ctrl   <= ex_mem_q.ctrl;
      mem_wb_result <= ex_mem_q.result;
      mem_wb_dst    <= ex_mem_q.dst;
      hlt           <= hlt | ex_mem_q.ctrl.halt;  // Sticky until reset
    end
  end

  // Writeback mux
  assign wb = '{valid: mem_wb_ctrl.reg_write,
                dst:   mem_wb_dst,
                data:  mem_wb_ctrl.mem_to_reg ? mem_rdata : mem_wb_result};

endmodule

`default_nettype wire

// File: rtl/data_mem.sv
`default_nettype none

module data_mem #(
  parameter int DMEM_AW = 8
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [15:0] addr,
  input  logic [15:0] wdata,
  input  logic        we,
  input  logic        re,
  output logic [15:0] rdata
);

  logic [15:0]        mem [2**DMEM_AW];
  logic [DMEM_AW-1:0] widx;

  assign widx = addr[DMEM_AW:1];  // Byte address to word index

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**DMEM_AW; i++) begin
        mem[i] <= 16'h0000;
      end
      rdata <= 16'h0000;
    end else begin
      if (we) begin
        mem[widx] <= wdata;
      end
      if (re) begin
        rdata <= mem[widx];  // Lands in writeback cycle
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/decode_unit.sv
`default_nettype none

module decode_unit (
  input  cpu_pkg::instr_u  instr,
  input  logic             halted,
  output logic [3:0]       ra,
  output logic [3:0]       rb,
  input  logic [15:0]      da,
  input  logic [15:0]      db,
  output cpu_pkg::id_ex_t  id_ex
);
  import cpu_pkg::*;

  ctrl_t       ctrl;
  logic [15:0] imm;

  // Register selects
  always_comb begin
    ra = instr.r.rs;
    rb = instr.r.rt;
    case (instr.r.op)
      OP_LLB, OP_LHB: ra = instr.i.rd;   // Old value gets merged
      OP_SW:          rb = instr.i.rd;   // Store data
      default:        rb = instr.r.rt;
    endcase
  end

  // Immediate view of the same word
  always_comb begin
    case (instr.i.op)
      OP_LW, OP_SW:   imm = {{11{instr.i.imm8[3]}}, instr.i.imm8[3:0], 1'b0};
      OP_LLB, OP_LHB: imm = {8'h00, instr.i.imm8};
      default:        imm = 16'h0000;
    endcase
  end

  ////////////////////
  // Control
  ////////////////////
  always_comb begin
    ctrl = NOP_CTRL;
    if (!halted) begin  // Everything after HLT is squashed
      case (instr.r.op)
        OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR, OP_SLL, OP_SRL: begin
          ctrl.alu_op    = instr.r.op;
          ctrl.reg_write = 1'b1;
        end
        OP_LW: begin
          ctrl.alu_op     = OP_LW;
          ctrl.use_imm    = 1'b1;
          ctrl.mem_read   = 1'b1;
          ctrl.reg_write  = 1'b1;
          ctrl.mem_to_reg = 1'b1;
        end
        OP_SW: begin
          ctrl.alu_op    = OP_SW;
          ctrl.use_imm   = 1'b1;
          ctrl.mem_write = 1'b1;
        end
        OP_LLB, OP_LHB: begin
          ctrl.alu_op    = instr.i.op;
          ctrl.use_imm   = 1'b1;
          ctrl.reg_write = 1'b1;
        end
        OP_HLT:  ctrl.halt = 1'b1;
        default: ctrl = NOP_CTRL;
      endcase
    end
  end

  assign id_ex = '{ctrl: ctrl, opa: da, opb: db, imm: imm, dst: instr.r.rd};

endmodule

`default_nettype wire

// File: rtl/alu.sv
`default_nettype none

module alu (
  input  cpu_pkg::opcode_e op,
  input  logic [15:0]      a,
  input  logic [15:0]      b,
  output logic [15:0]      y
);
  import cpu_pkg::*;

  always_comb begin
    case (op)
      OP_ADD: begin
        y = a + b;  // Wraps
      end
      OP_SUB: begin
        y = a - b;
      end
      OP_XOR: begin
        y = a ^ b;
      end
      OP_AND: begin
        y = a & b;
      end
      OP_OR: begin
        y = a | b;
      end
      OP_SLL: begin
        y = a << b[3:0];
      end
      OP_SRL: begin
        y = a >> b[3:0];  // Logical
      end
      // Address calc as base plus scaled offset
      OP_LW, OP_SW: begin
        y = a + b;
      end
      OP_LLB: begin
        y = {a[15:8], b[7:0]};
      end
      OP_LHB: begin
        y = {b[7:0], a[7:0]};
      end
      default: begin
        y = 16'h0000;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

module reg_file (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [3:0]  ra,
  input  logic [3:0]  rb,
  input  logic        we,
  input  logic [3:0]  wa,
  input  logic [15:0] wd,
  output logic [15:0] da,
  output logic [15:0] db
);

  logic [15:0] regs [16];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= 16'h0000;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  // Write-before-read bypass
  always_comb begin
    if (we && (wa == ra)) begin
      da = wd;
    end else begin
      da = regs[ra];
    end

    if (we && (wa == rb)) begin
      db = wd;
    end else begin
      db = regs[rb];
    end
  end

endmodule

`default_nettype wire

// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  ////////////////////
  // Opcodes
  ////////////////////
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_AND = 4'h3,
    OP_OR  = 4'h4,
    OP_SLL = 4'h5,
    OP_SRL = 4'h6,
    OP_NOP = 4'h7,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    OP_HLT = 4'hF   // C to E fall through as NOP
  } opcode_e;

  // Register format with op rd rs rt
  typedef struct packed {
    opcode_e    op;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } instr_r_t;

  // Immediate format with imm8 as {rs, offset} for LW/SW
  typedef struct packed {
    opcode_e    op;
    logic [3:0] rd;
    logic [7:0] imm8;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  ////////////////////
  // Pipeline payloads
  ////////////////////
  typedef struct packed {
    opcode_e alu_op;
    logic    use_imm;     // ALU b from imm
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
    logic    halt;
  } ctrl_t;

  typedef struct packed {
    ctrl_t       ctrl;
    logic [15:0] opa;
    logic [15:0] opb;
    logic [15:0] imm;
    logic [3:0]  dst;
  } id_ex_t;

  typedef struct packed {
    ctrl_t       ctrl;
    logic [15:0] result;
    logic [15:0] store_data;
    logic [3:0]  dst;
  } ex_mem_t;

  typedef struct packed {
    logic        valid;
    logic [3:0]  dst;
    logic [15:0] data;
  } wb_t;

  localparam ctrl_t       NOP_CTRL = '{alu_op: OP_NOP, default: '0};
  localparam logic [15:0] NOP_WORD = {OP_NOP, 12'h000};

endpackage

`default_nettype wire
